/* bench/mem_model.sv */
`timescale 1ns/1ps

module mem_model import spe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_stall,
    input  logic              wr_stall,
    input  logic [2:0]        rd_lat,
    input  logic              rd_read,
    input  logic [ADDR_W-1:0] rd_address,
    output logic              rd_waitrequest,
    output logic [DATA_W-1:0] rd_readdata,
    output logic              rd_readdatavalid,
    input  logic              wr_write,
    input  logic [ADDR_W-1:0] wr_address,
    input  logic [DATA_W-1:0] wr_writedata,
    output logic              wr_waitrequest
);

    logic [DATA_W-1:0] src [64];
    logic [DATA_W-1:0] dst [64];
    int unsigned       cyc;
    int unsigned       due;
    int unsigned       last_due;
    int unsigned       due_q [$]; // Return cycle of each accepted read.
    logic [DATA_W-1:0] data_q [$];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
            rd_waitrequest <= 1'b1;
            wr_waitrequest <= 1'b1;
            rd_readdatavalid <= 1'b0;
            rd_readdata <= '0;
            last_due = 0;
            due_q.delete();
            data_q.delete();
        end else begin
            cyc <= cyc + 1;
            rd_waitrequest <= rd_stall;
            wr_waitrequest <= wr_stall;
            rd_readdatavalid <= 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cyc) begin
                rd_readdatavalid <= 1'b1;
                rd_readdata <= data_q.pop_front();
                void'(due_q.pop_front());
            end
            if (rd_read && !rd_waitrequest) begin
                due = cyc + rd_lat;
                if (due <= last_due) due = last_due + 1; // Keep returns in order.
                last_due = due;
                due_q.push_back(due);
                data_q.push_back(src[rd_address[5:0]]);
            end
            if (wr_write && !wr_waitrequest) dst[wr_address[5:0]] <= wr_writedata;
        end
    end

endmodule

/* bench/spe_tb.sv */
`timescale 1ns/1ps

module spe_tb import spe_pkg::*; ();

    localparam int     NUM_TESTS = 12;
    localparam longint WATCHDOG_NS = NUM_TESTS * (48 * 40 + 200) * 40;

    logic                  clk;
    logic                  rst_n;
    logic [CSR_ADDR_W-1:0] csr_address;
    logic [31:0]           csr_writedata;
    logic                  csr_write;
    logic                  csr_read;
    logic [31:0]           csr_readdata;
    logic                  rd_read, rd_waitrequest, rd_readdatavalid;
    logic [ADDR_W-1:0]     rd_address;
    logic [DATA_W-1:0]     rd_readdata;
    logic                  wr_write, wr_waitrequest;
    logic [ADDR_W-1:0]     wr_address;
    logic [DATA_W-1:0]     wr_writedata;
    logic                  rd_stall, wr_stall, dense;
    logic [2:0]            rd_lat;
    logic [31:0]           lfsr = 32'ha078fab5;
    logic [DATA_W-1:0]     exp_src [64];
    op_t                   job_op;
    logic [31:0]           job_arg;
    int                    job_len;
    int                    errors, checks, tests_run, tests_failed;

    spe_top uut (
        .clk(clk), .rst_n(rst_n),
        .csr_address(csr_address), .csr_writedata(csr_writedata), .csr_write(csr_write),
        .csr_read(csr_read), .csr_readdata(csr_readdata),
        .rd_read(rd_read), .rd_address(rd_address), .rd_waitrequest(rd_waitrequest),
        .rd_readdata(rd_readdata), .rd_readdatavalid(rd_readdatavalid),
        .wr_write(wr_write), .wr_address(wr_address), .wr_writedata(wr_writedata),
        .wr_waitrequest(wr_waitrequest)
    );

    mem_model mem (
        .clk(clk), .rst_n(rst_n), .rd_stall(rd_stall), .wr_stall(wr_stall), .rd_lat(rd_lat),
        .rd_read(rd_read), .rd_address(rd_address), .rd_waitrequest(rd_waitrequest),
        .rd_readdata(rd_readdata), .rd_readdatavalid(rd_readdatavalid),
        .wr_write(wr_write), .wr_address(wr_address), .wr_writedata(wr_writedata),
        .wr_waitrequest(wr_waitrequest)
    );

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // Galois step.
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [63:0] model_op(input op_t op, input logic [63:0] d,
                                             input logic [31:0] arg);
        logic [31:0] hi;
        logic [31:0] lo;
        int          amt;
        hi = d[63:32];
        lo = d[31:0];
        amt = arg[5:0];
        case (op)
            OP_ADD:  return {hi + arg, lo + arg};
            OP_XOR:  return {hi ^ arg, lo ^ arg};
            OP_ROTL: return (amt == 0) ? d : ((d << amt) | (d >> (64 - amt)));
            default: return d;
        endcase
    endfunction

    function automatic logic [63:0] marker_word(input int i);
        return 64'hfeed_f00d_0000_0000 | i;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic csr_wr(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_address <= addr;
        csr_writedata <= data;
        csr_write <= 1'b1;
        @(posedge clk);
        csr_write <= 1'b0;
    endtask

    task automatic csr_rd(input logic [CSR_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        csr_address <= addr;
        csr_read <= 1'b1;
        @(posedge clk);
        csr_read <= 1'b0;
        @(negedge clk);
        data = csr_readdata; // Registered, holds until the next read.
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[0]) csr_rd(REG_STATUS, st);
    endtask

    // Random source, marked destination, then program the job registers.
    task automatic setup_job(input op_t op, input int fixed_len);
        logic [63:0] r;
        @(posedge clk);
        for (int i = 0; i < 64; i++) begin
            exp_src[i] = rand_bits(64);
            mem.src[i] = exp_src[i];
            mem.dst[i] = marker_word(i);
        end
        r = rand_bits(32);
        job_arg = r[31:0];
        r = rand_bits(6);
        job_len = (fixed_len != 0) ? fixed_len : int'(r[5:0]) % 48 + 1;
        job_op = op;
        csr_wr(REG_OPCODE, {30'd0, op});
        csr_wr(REG_OPERAND, job_arg);
        csr_wr(REG_LENGTH, job_len);
    endtask

    task automatic check_job(input string name);
        logic [31:0] v;
        for (int i = 0; i < 64; i++) begin
            if (i < job_len)
                check($sformatf("%s word %0d", name, i),
                      model_op(job_op, exp_src[i], job_arg), mem.dst[i]);
            else
                check($sformatf("%s marker %0d", name, i), marker_word(i), mem.dst[i]);
        end
        csr_rd(REG_RECV_COUNT, v);
        check({name, " recv count"}, job_len, v);
        csr_rd(REG_SEND_COUNT, v);
        check({name, " send count"}, job_len, v);
        csr_rd(REG_STATUS, v);
        check({name, " status"}, 64'd1, v); // Done, no longer busy.
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic run_job(input string name, input op_t op, input logic dense_mode);
        int e;
        e = errors;
        csr_wr(REG_CONTROL, 32'h2); // Clear, which also stops the engine.
        dense = dense_mode;
        setup_job(op, 0);
        csr_wr(REG_CONTROL, 32'h1);
        wait_done();
        check_job(name);
        finish_test(name, e);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory wait states and latency, drawn away from the rising edge.
    always @(negedge clk) begin
        logic [63:0] r;
        r = rand_bits(6);
        rd_stall = dense ? (r[1:0] != 2'b00) : (r[1:0] == 2'b00);
        wr_stall = dense ? (r[3:2] != 2'b00) : (r[3:2] == 2'b00);
        rd_lat = {1'b0, r[5:4]} + 3'd1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run timed out waiting for done");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        op_t         op;
        logic [31:0] v;
        logic [63:0] r;
        int          e;
        rst_n = 1'b0;
        csr_address = '0;
        csr_writedata = '0;
        csr_write = 1'b0;
        csr_read = 1'b0;
        rd_stall = 1'b0;
        wr_stall = 1'b0;
        rd_lat = 3'd1;
        dense = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        e = errors;
        r = rand_bits(32);
        csr_wr(REG_OPCODE, 32'd2);
        csr_wr(REG_OPERAND, r[31:0]);
        csr_wr(REG_LENGTH, {r[15:0], r[31:16]});
        csr_rd(REG_OPCODE, v);
        check("csr_readback opcode", 64'd2, v);
        csr_rd(REG_OPERAND, v);
        check("csr_readback operand", r[31:0], v);
        csr_rd(REG_LENGTH, v);
        check("csr_readback length", {r[15:0], r[31:16]}, v);
        finish_test("csr_readback", e);

        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 2; j++) begin
                op = op_t'(k);
                run_job($sformatf("job_%s_%0d", op.name(), j), op, 1'b0);
            end
        end
        run_job("dense_wait_add", OP_ADD, 1'b1);
        run_job("dense_wait_rotl", OP_ROTL, 1'b1);

        // Long job stopped part way, then a fresh job with another opcode.
        e = errors;
        csr_wr(REG_CONTROL, 32'h2);
        dense = 1'b0;
        setup_job(OP_XOR, 48);
        csr_wr(REG_CONTROL, 32'h1);
        repeat (60) @(posedge clk);
        csr_rd(REG_STATUS, v);
        check("clear_restart status mid-job", 64'd2, v); // Busy, not yet done.
        csr_wr(REG_CONTROL, 32'h2);
        repeat (30) @(posedge clk); // Let stale read returns drain.
        csr_rd(REG_RECV_COUNT, v);
        check("clear_restart recv after clear", 64'd0, v);
        csr_rd(REG_SEND_COUNT, v);
        check("clear_restart send after clear", 64'd0, v);
        setup_job(OP_ROTL, 0);
        csr_wr(REG_CONTROL, 32'h1);
        wait_done();
        check_job("clear_restart");
        finish_test("clear_restart", e);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/spe_pkg.sv
rtl/sync_fifo.sv
rtl/spe_csr.sv
rtl/stream_reader.sv
rtl/lane_alu.sv
rtl/stream_writer.sv
rtl/spe_top.sv
bench/mem_model.sv
bench/spe_tb.sv

/* rtl/lane_alu.sv */
`timescale 1ns/1ps

module lane_alu import spe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              clear,
    input  op_t               opcode,
    input  logic [31:0]       operand,
    input  logic              in_empty,
    input  logic [DATA_W-1:0] in_head,
    output logic              in_pop,
    input  logic              out_almost_full,
    output logic              out_push,
    output logic [DATA_W-1:0] out_data
);

    logic              s1_valid;
    logic [DATA_W-1:0] s1_data;
    op_t               s1_op;
    logic [31:0]       s1_operand;
    logic              s2_valid;
    logic [DATA_W-1:0] s2_data;

    function automatic logic [DATA_W-1:0] apply_op(
        input op_t op,
        input logic [DATA_W-1:0] d,
        input logic [31:0] arg
    );
        logic [2*DATA_W-1:0] dbl;
        dbl = {d, d} << arg[5:0];
        case (op)
            OP_ADD:  apply_op = {d[63:32] + arg, d[31:0] + arg}; // Halves wrap independently.
            OP_XOR:  apply_op = d ^ {arg, arg};
            OP_ROTL: apply_op = dbl[2*DATA_W-1:DATA_W];
            default: apply_op = d;
        endcase
    endfunction

    assign in_pop = ~in_empty & run & ~out_almost_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (clear) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_pop;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_data <= in_head;
        s1_op <= opcode;   // Captured with the word.
        s1_operand <= operand;
        s2_data <= apply_op(s1_op, s1_data, s1_operand);
    end

    assign out_push = s2_valid;
    assign out_data = s2_data;

endmodule

/* rtl/spe_csr.sv */
`timescale 1ns/1ps

module spe_csr import spe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CSR_ADDR_W-1:0] csr_address,
    input  logic [31:0]           csr_writedata,
    input  logic                  csr_write,
    input  logic                  csr_read,
    output logic [31:0]           csr_readdata,
    input  logic [ADDR_W-1:0]     rd_count,
    input  logic [ADDR_W-1:0]     wr_count,
    output logic                  run,
    output logic                  clear,
    output op_t                   opcode,
    output logic [31:0]           operand,
    output logic [ADDR_W-1:0]     length
);

    logic done;
    logic busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
            clear <= 1'b0;
            opcode <= OP_PASS;
            operand <= '0;
            length <= '0;
        end else begin
            clear <= 1'b0; // Self-clearing.
            if (csr_write) begin
                case (csr_address)
                    REG_CONTROL: begin
                        // A clear also stops the engine.
                        run <= csr_writedata[0] & ~csr_writedata[1];
                        clear <= csr_writedata[1];
                    end
                    REG_OPCODE:  opcode <= op_t'(csr_writedata[1:0]);
                    REG_OPERAND: operand <= csr_writedata;
                    REG_LENGTH:  length <= csr_writedata[ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Job is complete once every word has been written back.
    assign done = (wr_count == length) && (length != '0);
    assign busy = run & ~done;

    always_ff @(posedge clk) begin
        if (csr_read) begin
            case (csr_address)
                REG_CONTROL:    csr_readdata <= {30'd0, clear, run};
                REG_OPCODE:     csr_readdata <= {30'd0, opcode};
                REG_OPERAND:    csr_readdata <= operand;
                REG_LENGTH:     csr_readdata <= length;
                REG_STATUS:     csr_readdata <= {30'd0, busy, done};
                REG_RECV_COUNT: csr_readdata <= rd_count;
                REG_SEND_COUNT: csr_readdata <= wr_count;
                default:        csr_readdata <= '0;
            endcase
        end
    end

    // The send count never runs past the job.
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n || clear)
        (length != '0) |-> (wr_count <= length))
        else $error("spe_csr: more words written than the job length");

endmodule

/* rtl/spe_pkg.sv */
package spe_pkg;

    localparam int DATA_W = 64;
    localparam int ADDR_W = 32;
    localparam int CSR_ADDR_W = 3;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;
    localparam int MAX_OUTSTANDING = 4;
    // Leaves room for the reads still in flight.
    localparam int AFULL_LEVEL = FIFO_DEPTH - MAX_OUTSTANDING;

    localparam logic [CSR_ADDR_W-1:0] REG_CONTROL = 3'd0; // Bit 0 run, bit 1 clear.
    localparam logic [CSR_ADDR_W-1:0] REG_OPCODE = 3'd1;
    localparam logic [CSR_ADDR_W-1:0] REG_OPERAND = 3'd2;
    localparam logic [CSR_ADDR_W-1:0] REG_LENGTH = 3'd3;
    localparam logic [CSR_ADDR_W-1:0] REG_STATUS = 3'd4; // Bit 0 done, bit 1 busy.
    localparam logic [CSR_ADDR_W-1:0] REG_RECV_COUNT = 3'd5;
    localparam logic [CSR_ADDR_W-1:0] REG_SEND_COUNT = 3'd6;

    typedef enum logic [1:0] {
        OP_PASS, // Copy.
        OP_ADD,  // Add operand to each 32-bit half.
        OP_XOR,  // XOR with operand in both halves.
        OP_ROTL  // Rotate left by operand[5:0].
    } op_t;

endpackage

/* rtl/spe_top.sv */
`timescale 1ns/1ps

module spe_top import spe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [CSR_ADDR_W-1:0] csr_address,
    input  logic [31:0]           csr_writedata,
    input  logic                  csr_write,
    input  logic                  csr_read,
    output logic [31:0]           csr_readdata,

    output logic                  rd_read,
    output logic [ADDR_W-1:0]     rd_address,
    input  logic                  rd_waitrequest,
    input  logic [DATA_W-1:0]     rd_readdata,
    input  logic                  rd_readdatavalid,

    output logic                  wr_write,
    output logic [ADDR_W-1:0]     wr_address,
    output logic [DATA_W-1:0]     wr_writedata,
    input  logic                  wr_waitrequest
);

    logic              run;
    logic              clear;
    op_t               opcode;
    logic [31:0]       operand;
    logic [ADDR_W-1:0] length;
    logic [ADDR_W-1:0] rd_count;
    logic [ADDR_W-1:0] wr_count;

    logic              recv_push;
    logic [DATA_W-1:0] recv_push_data;
    logic              recv_pop;
    logic [DATA_W-1:0] recv_head;
    logic              recv_empty;
    logic              recv_afull;

    logic              send_push;
    logic [DATA_W-1:0] send_push_data;
    logic              send_pop;
    logic [DATA_W-1:0] send_head;
    logic              send_empty;
    logic              send_afull;

    spe_csr csr_i (
        .clk(clk), .rst_n(rst_n),
        .csr_address(csr_address), .csr_writedata(csr_writedata),
        .csr_write(csr_write), .csr_read(csr_read), .csr_readdata(csr_readdata),
        .rd_count(rd_count), .wr_count(wr_count),
        .run(run), .clear(clear), .opcode(opcode), .operand(operand), .length(length)
    );

    stream_reader reader_i (
        .clk(clk), .rst_n(rst_n), .run(run), .clear(clear), .length(length),
        .rd_read(rd_read), .rd_address(rd_address), .rd_waitrequest(rd_waitrequest),
        .rd_readdatavalid(rd_readdatavalid), .rd_readdata(rd_readdata),
        .fifo_almost_full(recv_afull), .fifo_push(recv_push),
        .fifo_push_data(recv_push_data), .rd_count(rd_count)
    );

    sync_fifo recv_fifo (
        .clk(clk), .rst_n(rst_n), .clear(clear),
        .push(recv_push), .push_data(recv_push_data), .pop(recv_pop),
        .head(recv_head), .empty(recv_empty), .almost_full(recv_afull), .level()
    );

    lane_alu alu_i (
        .clk(clk), .rst_n(rst_n), .run(run), .clear(clear),
        .opcode(opcode), .operand(operand),
        .in_empty(recv_empty), .in_head(recv_head), .in_pop(recv_pop),
        .out_almost_full(send_afull), .out_push(send_push), .out_data(send_push_data)
    );

    sync_fifo send_fifo (
        .clk(clk), .rst_n(rst_n), .clear(clear),
        .push(send_push), .push_data(send_push_data), .pop(send_pop),
        .head(send_head), .empty(send_empty), .almost_full(send_afull), .level()
    );

    stream_writer writer_i (
        .clk(clk), .rst_n(rst_n), .clear(clear),
        .fifo_empty(send_empty), .fifo_head(send_head), .fifo_pop(send_pop),
        .wr_write(wr_write), .wr_address(wr_address), .wr_writedata(wr_writedata),
        .wr_waitrequest(wr_waitrequest), .wr_count(wr_count)
    );

endmodule

/* rtl/stream_reader.sv */
`timescale 1ns/1ps

module stream_reader import spe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              clear,
    input  logic [ADDR_W-1:0] length,
    output logic              rd_read,
    output logic [ADDR_W-1:0] rd_address,
    input  logic              rd_waitrequest,
    input  logic              rd_readdatavalid,
    input  logic [DATA_W-1:0] rd_readdata,
    input  logic              fifo_almost_full,
    output logic              fifo_push,
    output logic [DATA_W-1:0] fifo_push_data,
    output logic [ADDR_W-1:0] rd_count
);

    logic [ADDR_W-1:0] req_cnt;  // Reads launched, also the next address.
    logic [2:0]        out_cnt;  // Accepted and not yet returned.
    logic [2:0]        discard;  // Stale returns left over from a clear.
    logic              accept;
    logic              live_valid;
    logic              can_launch;

    assign accept = rd_read & ~rd_waitrequest;
    assign live_valid = rd_readdatavalid & (discard == '0);

    assign can_launch = run && !fifo_almost_full && (discard == '0)
                        && ((out_cnt + accept) < MAX_OUTSTANDING)
                        && (req_cnt < length);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_read <= 1'b0;
            rd_address <= '0;
            req_cnt <= '0;
            out_cnt <= '0;
            discard <= '0;
            rd_count <= '0;
        end else if (clear) begin
            rd_read <= 1'b0;
            rd_address <= '0;
            req_cnt <= '0;
            out_cnt <= '0;
            rd_count <= '0;
            // Reads already accepted will still come back.
            discard <= discard + out_cnt + {2'b0, accept} - {2'b0, rd_readdatavalid};
        end else begin
            if (!rd_read || accept) begin
                rd_read <= can_launch;
                if (can_launch) begin
                    rd_address <= req_cnt;
                    req_cnt <= req_cnt + 1'b1;
                end
            end
            out_cnt <= out_cnt + {2'b0, accept} - {2'b0, live_valid};
            if (rd_readdatavalid && discard != '0) discard <= discard - 1'b1;
            if (fifo_push) rd_count <= rd_count + 1'b1;
        end
    end

    assign fifo_push = live_valid & ~clear;
    assign fifo_push_data = rd_readdata;

    a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= MAX_OUTSTANDING)
        else $error("stream_reader: too many reads in flight");

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n || clear)
        (rd_read && rd_waitrequest) |=> (rd_read && $stable(rd_address)))
        else $error("stream_reader: request changed under waitrequest");

endmodule

/* rtl/stream_writer.sv */
`timescale 1ns/1ps

module stream_writer import spe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              fifo_empty,
    input  logic [DATA_W-1:0] fifo_head,
    output logic              fifo_pop,
    output logic              wr_write,
    output logic [ADDR_W-1:0] wr_address,
    output logic [DATA_W-1:0] wr_writedata,
    input  logic              wr_waitrequest,
    output logic [ADDR_W-1:0] wr_count
);

    logic accept;

    assign accept = wr_write & ~wr_waitrequest;
    assign fifo_pop = accept; // Head leaves the FIFO as the write lands.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_write <= 1'b0;
            wr_count <= '0;
        end else if (clear) begin
            wr_write <= 1'b0;
            wr_count <= '0;
        end else begin
            if (accept) begin
                // Head is stale this cycle, reload on the next one.
                wr_write <= 1'b0;
                wr_count <= wr_count + 1'b1;
            end else if (!wr_write && !fifo_empty) begin
                wr_write <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!wr_write && !fifo_empty) begin
            wr_writedata <= fifo_head;
        end
    end

    // Count only moves on acceptance, so it holds under waitrequest.
    assign wr_address = wr_count;

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n || clear)
        (wr_write && wr_waitrequest) |=>
            (wr_write && $stable(wr_address) && $stable(wr_writedata)))
        else $error("stream_writer: write changed under waitrequest");

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo import spe_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] head,
    output logic              empty,
    output logic              almost_full,
    output logic [FIFO_AW:0]  level
);

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge clk) begin
        if (push && !clear) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else if (clear) begin
            wr_ptr <= '0; // Flush in one cycle.
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rd_ptr]; // Show-ahead.
    assign empty = (count == '0);
    assign almost_full = (count >= AFULL_LEVEL);
    assign level = count;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || clear)
        !(push && !pop && count == FIFO_DEPTH))
        else $error("sync_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || clear)
        !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule
